// ==== common/fifo_config.svh ====
/* static configuration of the synchronous FIFO controller
   include wherever depth, address width or thresholds are needed */

`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// --------------------
// geometry
// --------------------

// memory address width, depth is a power of two
`define FIFO_ADDR_W 4

// number of entries in the external RAM
`define FIFO_DEPTH (1 << `FIFO_ADDR_W)

// --------------------
// static thresholds
// --------------------

// almost full sets at or above this level on a write
`define FIFO_AFULL_THRESH 11

// almost empty sets at or below this level on a read
`define FIFO_AEMPTY_THRESH 4

`endif

// ==== common/fifo_pkg.sv ====
/* shared types of the FIFO controller
   modules pull these in through a wildcard import */

`default_nettype none

`include "fifo_config.svh"

package fifo_pkg;

   // --------------------
   // pointer and address types
   // --------------------

   // one extra msb to tell full from empty
   typedef logic [`FIFO_ADDR_W:0] ptr_t;

   // low pointer bits, straight to the RAM address lines
   typedef logic [`FIFO_ADDR_W-1:0] addr_t;

   // --------------------
   // level count
   // --------------------

   // holds 0 up to FIFO_DEPTH inclusive
   typedef logic [`FIFO_ADDR_W:0] count_t;

endpackage

`default_nettype wire

// ==== fifo_ctrl/fifo_write_side.sv ====
/* write half of the FIFO controller, owns the write pointer
   drives the RAM write port and the full side status flags */

`timescale 1ns/1ps
`default_nettype none

`include "fifo_config.svh"

module fifo_write_side
   import fifo_pkg::*;
(
   input  wire logic   pos_clk,
   input  wire logic   aresetn,
   input  wire logic   we_i,
   input  wire ptr_t   rd_ptr_i,
   output ptr_t        wr_ptr_o,
   output logic        memwe_o,
   output addr_t       memwaddr_o,
   output logic        full_o,
   output logic        afull_o,
   output count_t      wrcnt_o,
   output logic        wack_o,
   output logic        overflow_o
);

   // thresholds in count width
   localparam count_t AFULL_TH = count_t'(`FIFO_AFULL_THRESH);
   localparam count_t DEPTH    = count_t'(`FIFO_DEPTH);

   logic   wr_acc;
   ptr_t   wr_ptr;
   ptr_t   wr_ptr_nxt;
   count_t wdiff;

   // --------------------
   // accept and pointer math
   // --------------------

   // write refused while full, pointer stays put
   assign wr_acc = we_i & ~full_o;

   // pointer after this cycle's write
   assign wr_ptr_nxt = wr_ptr + ptr_t'(wr_acc);

   // level seen from the write side, wraps mod 2*depth
   assign wdiff = count_t'(wr_ptr_nxt - rd_ptr_i);

   // --------------------
   // RAM write port
   // --------------------

   // enable reacts in the same cycle
   assign memwe_o = wr_acc;

   // address is the low pointer bits, wraps on its own
   assign memwaddr_o = wr_ptr[`FIFO_ADDR_W-1:0];

   // handed to the read side
   assign wr_ptr_o = wr_ptr;

   // --------------------
   // registered state
   // --------------------

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_ptr     <= '0;
         full_o     <= 1'b0;
         afull_o    <= 1'b0;
         wrcnt_o    <= '0;
         wack_o     <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         wr_ptr <= wr_ptr_nxt;

         // full once the level hits the depth
         full_o  <= (wdiff == DEPTH);
         wrcnt_o <= wdiff;

         // almost full with hysteresis
         // set needs a write request, clear does not
         // between the two it holds
         if (we_i && (wdiff >= AFULL_TH)) begin
            afull_o <= 1'b1;
         end else if (wdiff <= AFULL_TH) begin
            afull_o <= 1'b0;
         end

         // ack one cycle after an accepted write
         wack_o <= wr_acc;

         // request against a full FIFO
         overflow_o <= we_i & full_o;
      end
   end

endmodule

`default_nettype wire

// ==== fifo_ctrl/fifo_read_side.sv ====
/* read half of the FIFO controller, owns the read pointer
   drives the RAM read port and the empty side status flags */

`timescale 1ns/1ps
`default_nettype none

`include "fifo_config.svh"

module fifo_read_side
   import fifo_pkg::*;
(
   input  wire logic   pos_clk,
   input  wire logic   aresetn,
   input  wire logic   re_i,
   input  wire ptr_t   wr_ptr_i,
   output ptr_t        rd_ptr_o,
   output logic        memre_o,
   output addr_t       memraddr_o,
   output logic        empty_o,
   output logic        aempty_o,
   output count_t      rdcnt_o,
   output logic        dvld_o,
   output logic        underflow_o
);

   // almost empty level in count width
   localparam count_t AEMPTY_TH = count_t'(`FIFO_AEMPTY_THRESH);

   logic   rd_acc;
   ptr_t   rd_ptr;
   ptr_t   rd_ptr_nxt;
   count_t rdiff;

   // --------------------
   // accept and pointer math
   // --------------------

   // read refused while empty
   assign rd_acc = re_i & ~empty_o;

   // pointer after this cycle's read
   assign rd_ptr_nxt = rd_ptr + ptr_t'(rd_acc);

   // level seen from the read side
   // current write pointer against the next read pointer
   assign rdiff = count_t'(wr_ptr_i - rd_ptr_nxt);

   // --------------------
   // RAM read port
   // --------------------

   // zero cycle enable
   assign memre_o = rd_acc;

   // low pointer bits, natural wrap from 15 to 0
   assign memraddr_o = rd_ptr[`FIFO_ADDR_W-1:0];

   // handed to the write side
   assign rd_ptr_o = rd_ptr;

   // --------------------
   // registered state
   // --------------------

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_ptr      <= '0;
         empty_o     <= 1'b1;
         aempty_o    <= 1'b1;
         rdcnt_o     <= '0;
         dvld_o      <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         rd_ptr <= rd_ptr_nxt;

         // empty when nothing is left after this read
         empty_o <= (rdiff == '0);
         rdcnt_o <= rdiff;

         // almost empty with hysteresis
         // clear only while set, set needs a read request
         if (aempty_o && (rdiff >= AEMPTY_TH)) begin
            aempty_o <= 1'b0;
         end else if (re_i && (rdiff <= AEMPTY_TH)) begin
            aempty_o <= 1'b1;
         end

         // data valid trails the RAM read by one cycle
         dvld_o <= rd_acc;

         // request against an empty FIFO
         underflow_o <= re_i & empty_o;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/fifo_sync_ctrl.sv ====
/* single clock FIFO controller top, drives an external dual-port RAM
   joins the write side and read side through their pointers */

`timescale 1ns/1ps
`default_nettype none

`include "fifo_config.svh"

module fifo_sync_ctrl
   import fifo_pkg::*;
(
   input  wire logic   pos_clk,
   input  wire logic   aresetn,
   input  wire logic   we_i,
   input  wire logic   re_i,
   // write side
   output logic        memwe_o,
   output addr_t       memwaddr_o,
   output logic        full_o,
   output logic        afull_o,
   output count_t      wrcnt_o,
   output logic        wack_o,
   output logic        overflow_o,
   // read side
   output logic        memre_o,
   output addr_t       memraddr_o,
   output logic        empty_o,
   output logic        aempty_o,
   output count_t      rdcnt_o,
   output logic        dvld_o,
   output logic        underflow_o
);

   // registered pointers crossing between the halves
   ptr_t wr_ptr;
   ptr_t rd_ptr;

   // --------------------
   // write half
   // --------------------

   fifo_write_side u_write_side (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .we_i       (we_i),
      .rd_ptr_i   (rd_ptr),
      .wr_ptr_o   (wr_ptr),
      .memwe_o    (memwe_o),
      .memwaddr_o (memwaddr_o),
      .full_o     (full_o),
      .afull_o    (afull_o),
      .wrcnt_o    (wrcnt_o),
      .wack_o     (wack_o),
      .overflow_o (overflow_o)
   );

   // --------------------
   // read half
   // --------------------

   fifo_read_side u_read_side (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .re_i        (re_i),
      .wr_ptr_i    (wr_ptr),
      .rd_ptr_o    (rd_ptr),
      .memre_o     (memre_o),
      .memraddr_o  (memraddr_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o),
      .rdcnt_o     (rdcnt_o),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o)
   );

endmodule

`default_nettype wire

// ==== verification/fifo_sync_ctrl_checker.sv ====
/* protocol assertions on the FIFO controller top
   bound into every fifo_sync_ctrl instance */

`timescale 1ns/1ps
`default_nettype none

module fifo_sync_ctrl_checker (
   input wire logic pos_clk,
   input wire logic aresetn,
   input wire logic full_i,
   input wire logic empty_i,
   input wire logic memwe_i,
   input wire logic wack_i
);

   // --------------------
   // flag consistency
   // --------------------

   // a level cannot be 0 and the depth at once
   a_full_empty_excl: assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(full_i && empty_i))
      else $error("full and empty high together");

   // no RAM write into a full FIFO
   a_no_write_when_full: assert property (@(posedge pos_clk) disable iff (!aresetn)
      memwe_i |-> !full_i)
      else $error("memory write enable while full");

   // ack is the write enable one cycle late
   a_wack_follows_we: assert property (@(posedge pos_clk) disable iff (!aresetn)
      wack_i == $past(memwe_i))
      else $error("write ack does not follow the write enable");

endmodule

bind fifo_sync_ctrl fifo_sync_ctrl_checker u_checker (
   .pos_clk (pos_clk),
   .aresetn (aresetn),
   .full_i  (full_o),
   .empty_i (empty_o),
   .memwe_i (memwe_o),
   .wack_i  (wack_o)
);

`default_nettype wire

// ==== verification/tb_fifo_sync_ctrl.sv ====
/* testbench for the FIFO controller with directed and seeded random traffic
   every output is compared each cycle with a cycle model of the flag rules */

`timescale 1ns/1ps
`default_nettype none

`include "fifo_config.svh"

module tb_fifo_sync_ctrl
   import fifo_pkg::*;
;

   localparam logic [31:0] SEED = 32'h9697_90da;
   localparam int RAND_CYCLES = 1500;
   // directed tests take under 400 cycles plus margin
   localparam int MAX_CYCLES = RAND_CYCLES + 400 + 500;
   localparam count_t AFULL_TH = count_t'(`FIFO_AFULL_THRESH);
   localparam count_t AEMPTY_TH = count_t'(`FIFO_AEMPTY_THRESH);
   localparam count_t DEPTH = count_t'(`FIFO_DEPTH);

   logic pos_clk, aresetn, we_i, re_i;
   logic memwe_o, full_o, afull_o, wack_o, overflow_o;
   logic memre_o, empty_o, aempty_o, dvld_o, underflow_o;
   addr_t memwaddr_o, memraddr_o;
   count_t wrcnt_o, rdcnt_o;

   // model state mirroring the registered outputs
   ptr_t m_wr, m_rd;
   logic m_full, m_empty, m_afull, m_aempty, m_wack, m_dvld, m_ovf, m_unf;
   count_t m_wrcnt, m_rdcnt;

   string cur_test;
   int checks = 0;
   int errors = 0;
   int test_errors = 0;
   int tests = 0;
   int tests_failed = 0;
   int cycles = 0;

   fifo_sync_ctrl u_dut (
      .pos_clk(pos_clk), .aresetn(aresetn), .we_i(we_i), .re_i(re_i),
      .memwe_o(memwe_o), .memwaddr_o(memwaddr_o), .full_o(full_o), .afull_o(afull_o),
      .wrcnt_o(wrcnt_o), .wack_o(wack_o), .overflow_o(overflow_o),
      .memre_o(memre_o), .memraddr_o(memraddr_o), .empty_o(empty_o), .aempty_o(aempty_o),
      .rdcnt_o(rdcnt_o), .dvld_o(dvld_o), .underflow_o(underflow_o)
   );

   initial begin
      pos_clk = 1'b0;
      forever #50 pos_clk = ~pos_clk;
   end

   // hard stop in case a wait never returns
   always @(posedge pos_clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         $display("timeout, run still going after %0d cycles", MAX_CYCLES);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // --------------------
   // compare tasks
   // --------------------

   task automatic check_bit(input string what, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Error %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
      end
   endtask

   task automatic check_addr(input string what, input addr_t exp, input addr_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      end
   endtask

   task automatic check_count(input string what, input count_t exp, input count_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      end
   endtask

   // --------------------
   // reference model
   // --------------------

   task automatic model_reset();
      m_wr = '0;
      m_rd = '0;
      {m_full, m_afull, m_wack, m_dvld, m_ovf, m_unf} = '0;
      m_empty = 1'b1;
      m_aempty = 1'b1;
      m_wrcnt = '0;
      m_rdcnt = '0;
   endtask

   // one clock edge of the flag rules
   task automatic model_step(input logic we, input logic re);
      logic wacc, racc;
      ptr_t wnxt, rnxt;
      count_t wd, rd;
      wacc = we && !m_full;
      racc = re && !m_empty;
      wnxt = m_wr + ptr_t'(wacc);
      rnxt = m_rd + ptr_t'(racc);
      // write side sees the old read pointer and the other way round
      wd = count_t'(wnxt - m_rd);
      rd = count_t'(m_wr - rnxt);
      m_ovf = we && m_full;
      m_unf = re && m_empty;
      m_full = (wd == DEPTH);
      m_empty = (rd == '0);
      m_wrcnt = wd;
      m_rdcnt = rd;
      if (we && wd >= AFULL_TH) m_afull = 1'b1;
      else if (wd <= AFULL_TH) m_afull = 1'b0;
      if (m_aempty && rd >= AEMPTY_TH) m_aempty = 1'b0;
      else if (re && rd <= AEMPTY_TH) m_aempty = 1'b1;
      m_wack = wacc;
      m_dvld = racc;
      m_wr = wnxt;
      m_rd = rnxt;
   endtask

   task automatic check_all();
      check_bit("memwe_o", we_i && !m_full, memwe_o);
      check_addr("memwaddr_o", m_wr[`FIFO_ADDR_W-1:0], memwaddr_o);
      check_bit("full_o", m_full, full_o);
      check_bit("afull_o", m_afull, afull_o);
      check_count("wrcnt_o", m_wrcnt, wrcnt_o);
      check_bit("wack_o", m_wack, wack_o);
      check_bit("overflow_o", m_ovf, overflow_o);
      check_bit("memre_o", re_i && !m_empty, memre_o);
      check_addr("memraddr_o", m_rd[`FIFO_ADDR_W-1:0], memraddr_o);
      check_bit("empty_o", m_empty, empty_o);
      check_bit("aempty_o", m_aempty, aempty_o);
      check_count("rdcnt_o", m_rdcnt, rdcnt_o);
      check_bit("dvld_o", m_dvld, dvld_o);
      check_bit("underflow_o", m_unf, underflow_o);
   endtask

   // drive 1 ns after the edge and compare mid cycle before the model advances
   task automatic run_cycle(input logic we, input logic re);
      @(posedge pos_clk);
      #1;
      we_i = we;
      re_i = re;
      @(negedge pos_clk);
      check_all();
      model_step(we, re);
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_errors = errors;
   endtask

   task automatic finish_test();
      tests++;
      if (errors == test_errors) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", cur_test, errors - test_errors);
      end
   endtask

   // --------------------
   // test sequence
   // --------------------

   initial begin
      logic [31:0] r;
      addr_t held, last_w, last_r;
      int n_dvld, wraps_w, wraps_r;
      r = $urandom(SEED);
      we_i = 1'b0;
      re_i = 1'b0;
      aresetn = 1'b0;
      model_reset();
      repeat (8) @(posedge pos_clk);
      #1 aresetn = 1'b1;

      start_test("reset");
      @(negedge pos_clk);
      check_all();
      model_step(1'b0, 1'b0);
      finish_test();

      start_test("fill");
      repeat (16) run_cycle(1'b1, 1'b0);
      run_cycle(1'b1, 1'b0);
      check_bit("full after 16 writes", 1'b1, full_o);
      // address the model expects while the write is refused
      held = m_wr[`FIFO_ADDR_W-1:0];
      run_cycle(1'b0, 1'b0);
      check_bit("overflow after refused write", 1'b1, overflow_o);
      check_addr("write address held", held, memwaddr_o);
      finish_test();

      start_test("drain");
      n_dvld = 0;
      repeat (16) begin
         run_cycle(1'b0, 1'b1);
         n_dvld += int'(dvld_o);
      end
      run_cycle(1'b0, 1'b1);
      n_dvld += int'(dvld_o);
      check_count("dvld pulses", count_t'(16), count_t'(n_dvld));
      check_bit("empty after drain", 1'b1, empty_o);
      run_cycle(1'b0, 1'b0);
      check_bit("underflow after refused read", 1'b1, underflow_o);
      finish_test();

      start_test("almost");
      repeat (12) run_cycle(1'b1, 1'b0);
      run_cycle(1'b0, 1'b0);
      check_bit("afull set at 12", 1'b1, afull_o);
      run_cycle(1'b0, 1'b1);
      run_cycle(1'b0, 1'b0);
      check_bit("afull held", 1'b1, afull_o);
      run_cycle(1'b0, 1'b0);
      check_bit("afull cleared at 11", 1'b0, afull_o);
      repeat (8) run_cycle(1'b0, 1'b1);
      run_cycle(1'b0, 1'b0);
      check_bit("aempty set at 3", 1'b1, aempty_o);
      run_cycle(1'b1, 1'b0);
      run_cycle(1'b0, 1'b0);
      check_bit("aempty held", 1'b1, aempty_o);
      run_cycle(1'b0, 1'b0);
      check_bit("aempty cleared at 4", 1'b0, aempty_o);
      repeat (4) run_cycle(1'b0, 1'b1);
      run_cycle(1'b0, 1'b0);
      finish_test();

      // paced traffic keeps the level at 4 or 5
      start_test("wrap");
      repeat (4) run_cycle(1'b1, 1'b0);
      wraps_w = 0;
      wraps_r = 0;
      last_w = memwaddr_o;
      last_r = memraddr_o;
      for (int i = 0; i < 48; i++) begin
         run_cycle((i % 4) != 3, (i % 4) != 1);
         if (last_w == addr_t'(15) && memwaddr_o == addr_t'(0)) wraps_w++;
         if (last_r == addr_t'(15) && memraddr_o == addr_t'(0)) wraps_r++;
         last_w = memwaddr_o;
         last_r = memraddr_o;
      end
      check_bit("write address wrapped twice", 1'b1, wraps_w >= 2);
      check_bit("read address wrapped twice", 1'b1, wraps_r >= 2);
      finish_test();

      start_test("random");
      repeat (RAND_CYCLES) begin
         r = $urandom;
         run_cycle(r[0], r[1]);
      end
      finish_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/fifo_pkg.sv
fifo_ctrl/fifo_write_side.sv
fifo_ctrl/fifo_read_side.sv
hdl/fifo_sync_ctrl.sv
verification/fifo_sync_ctrl_checker.sv
verification/tb_fifo_sync_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the FIFO controller testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_fifo_sync_ctrl \
   -f verilog.f

# the pass line decides the result
out="$(./obj_dir/Vtb_fifo_sync_ctrl 2>&1)" || true
echo "$out"
grep -qF '*** PASSED ***' <<< "$out"
